// ==== flist.f ====
src/qspi_pkg.sv
src/qspi_inst_decode.sv
src/qspi_cmd_fifo.sv
src/qspi_cmd_issue.sv
src/qspi_decode_top.sv
test/qspi_tb_clock.sv
test/qspi_decode_tb.sv

// ==== Bender.yml ====
package:
  name: qspi_decode

sources:
  - src/qspi_pkg.sv
  - src/qspi_inst_decode.sv
  - src/qspi_cmd_fifo.sv
  - src/qspi_cmd_issue.sv
  - src/qspi_decode_top.sv
  - target: test
    files:
      - test/qspi_tb_clock.sv
      - test/qspi_decode_tb.sv

// ==== test/qspi_decode_tb.sv ====
`timescale 1ns/1ps

module qspi_decode_tb;

	localparam int N_REQ = 400;
	localparam int TIMEOUT = N_REQ * 20;

	// opcode classes of the model
	localparam int CLS_ILLEGAL = 0;
	localparam int CLS_DUMMY = 1;
	localparam int CLS_READ = 2;
	localparam int CLS_WRITE = 3;
	localparam int CLS_INST = 4;
	localparam int CLS_REG_RD = 5;
	localparam int CLS_REG_WR = 6;
	localparam int CLS_INST_ADDR = 7;

	// expected command, same field order as the output ports
	typedef struct packed {
		qspi_pkg::inst_t inst;
		logic label;
		qspi_pkg::addr_t addr;
		qspi_pkg::len_t data_size;
		qspi_pkg::len_t data_burstlen;
		logic wr_en;
		logic rd_en;
		logic addr_en;
		logic erase_en;
		logic dummy_en;
		qspi_pkg::len_t dummy_burstlen;
		logic addr_mode_en;
		logic addr_dpi_mode;
		logic data_mode_en;
		logic data_dpi_mode;
	} cmd_t;

	logic clock;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	qspi_pkg::inst_t req_inst;
	logic req_label;
	qspi_pkg::addr_t req_addr;
	qspi_pkg::len_t req_data_size;
	qspi_pkg::len_t req_data_burstlen;
	qspi_pkg::mode_t mode;
	logic write_enabled;
	logic resp_valid;
	logic resp_error;
	qspi_pkg::cause_t resp_cause;
	logic out_ready;
	logic out_valid;
	qspi_pkg::inst_t out_inst;
	logic out_label;
	qspi_pkg::addr_t out_addr;
	qspi_pkg::len_t out_data_size;
	qspi_pkg::len_t out_data_burstlen;
	logic out_wr_en;
	logic out_rd_en;
	logic out_addr_en;
	logic out_erase_en;
	logic out_dummy_en;
	qspi_pkg::len_t out_dummy_burstlen;
	logic out_addr_mode_en;
	logic out_addr_dpi_mode;
	logic out_data_mode_en;
	logic out_data_dpi_mode;

	// model state
	qspi_pkg::inst_t op_list [32];
	qspi_pkg::cause_t resp_q [$];
	cmd_t cmd_q [$];
	cmd_t seen;
	cmd_t seen_prev;
	cmd_t exp_cmd;
	qspi_pkg::cause_t exp_cause;
	logic started = 1'b0;
	logic accept_prev = 1'b0;
	logic stall_prev = 1'b0;
	int accepted = 0;
	int quiet = 0;
	int cycles = 0;
	int resp_errors = 0;
	int cmd_errors = 0;
	int flow_errors = 0;

	qspi_tb_clock clk0 (.clock(clock), .rst_n(rst_n));

	qspi_decode_top dut0 (.*);

	////////////////////////////////////////////////////////////
	// reference model

	function automatic int op_class(input qspi_pkg::inst_t op);
		case (op)
			8'h0b, 8'h3b, 8'hbb, 8'heb, 8'h4b, 8'h6b: return CLS_DUMMY;
			8'h03: return CLS_READ;
			8'h02, 8'ha2, 8'hd2, 8'h32, 8'h12, 8'h42: return CLS_WRITE;
			8'h06, 8'h04, 8'h50, 8'hc7, 8'h7a, 8'h75: return CLS_INST;
			8'h05, 8'hb5, 8'h85, 8'h65, 8'h70, 8'he8: return CLS_REG_RD;
			8'h01, 8'hb1, 8'h81, 8'h61, 8'he5: return CLS_REG_WR;
			8'h20, 8'hd8: return CLS_INST_ADDR;
			default: return CLS_ILLEGAL;
		endcase
	endfunction

	// illegal first, then write disabled, then link mode
	function automatic qspi_pkg::cause_t model_cause(input qspi_pkg::inst_t op,
		input qspi_pkg::mode_t md, input logic we);
		int cls;
		cls = op_class(op);
		if (cls == CLS_ILLEGAL)
			return 2'd1;
		if (cls == CLS_WRITE && !we)
			return 2'd2;
		// quad ops on a dual link
		if (md == 2'd1 && op inside {8'h6b, 8'heb, 8'h32, 8'h12})
			return 2'd3;
		// dual ops on a quad link, mode 3 counts as quad
		if (md >= 2'd2 && op inside {8'h3b, 8'hbb, 8'ha2, 8'hd2})
			return 2'd3;
		return 2'd0;
	endfunction

	function automatic cmd_t model_cmd(input qspi_pkg::inst_t op, input logic lb,
		input qspi_pkg::addr_t ad, input qspi_pkg::len_t sz, input qspi_pkg::len_t bl,
		input qspi_pkg::mode_t md);
		cmd_t c;
		int cls;
		cls = op_class(op);
		c.inst = op;
		c.label = lb;
		c.addr = ad;
		c.data_size = sz;
		c.data_burstlen = bl;
		c.wr_en = (cls == CLS_WRITE) || (cls == CLS_REG_WR);
		c.rd_en = (cls == CLS_DUMMY) || (cls == CLS_READ) || (cls == CLS_REG_RD);
		c.addr_en = (cls == CLS_WRITE) || (cls == CLS_READ) || (cls == CLS_DUMMY) ||
			(cls == CLS_INST_ADDR);
		c.erase_en = op inside {8'h20, 8'hd8, 8'hc7};
		c.dummy_en = (cls == CLS_DUMMY);
		// 2 spi, 4 dpi, 10 qpi
		c.dummy_burstlen = (md == 2'd0) ? 8'd2 : (md == 2'd1) ? 8'd4 : 8'd10;
		c.addr_mode_en = op inside {8'hbb, 8'heb, 8'ha2, 8'hd2};
		c.addr_dpi_mode = op inside {8'h6b, 8'hd2};
		c.data_mode_en = op inside {8'h3b, 8'hbb, 8'h6b, 8'heb, 8'ha2, 8'h32};
		c.data_dpi_mode = op inside {8'h3b, 8'hbb, 8'ha2};
		return c;
	endfunction

	task automatic log_error(inout int cnt, input string msg);
		cnt++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// three quarters listed opcodes, the rest any byte
	task automatic drive_request();
		if ($urandom_range(0, 3) != 0)
			req_inst = op_list[$urandom_range(0, 31)];
		else
			req_inst = qspi_pkg::inst_t'($urandom);
		req_valid = ($urandom_range(0, 9) < 7);
		req_label = $urandom_range(0, 1);
		req_addr = qspi_pkg::addr_t'($urandom);
		req_data_size = qspi_pkg::len_t'($urandom);
		req_data_burstlen = qspi_pkg::len_t'($urandom);
		mode = qspi_pkg::mode_t'($urandom_range(0, 3));
		write_enabled = ($urandom_range(0, 3) != 0);
		// transfer level stalls about 40% of cycles
		out_ready = ($urandom_range(0, 9) >= 4);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	initial
	begin
		void'($urandom(9608));
		op_list = '{8'h0b, 8'h3b, 8'hbb, 8'heb, 8'h4b, 8'h6b, 8'h03, 8'h02,
			8'ha2, 8'hd2, 8'h32, 8'h12, 8'h42, 8'h06, 8'h04, 8'h50,
			8'hc7, 8'h7a, 8'h75, 8'h05, 8'hb5, 8'h85, 8'h65, 8'h70,
			8'he8, 8'h01, 8'hb1, 8'h81, 8'h61, 8'he5, 8'h20, 8'hd8};
		req_valid = 1'b0;
		req_inst = '0;
		req_label = 1'b0;
		req_addr = '0;
		req_data_size = '0;
		req_data_burstlen = '0;
		mode = '0;
		write_enabled = 1'b0;
		out_ready = 1'b0;
		@(posedge rst_n);
		@(posedge clock);
		#1;
		while (accepted < N_REQ)
		begin
			drive_request();
			@(posedge clock);
			#1;
		end
		req_valid = 1'b0;
		// drain with the transfer level always ready
		out_ready = 1'b1;
		// pipe is empty once out_valid stays low longer than buffer plus register
		quiet = 0;
		while (quiet < qspi_pkg::CMD_DEPTH + 2)
		begin
			@(posedge clock);
			#1;
			if (out_valid)
				quiet = 0;
			else
				quiet++;
		end
		assert (resp_q.size() == 0 && cmd_q.size() == 0)
		else
			log_error(flow_errors, "model queues not empty after drain");
		$display("done: %0d accepted, %0d response, %0d command, %0d flow errors",
			accepted, resp_errors, cmd_errors, flow_errors);
		if (resp_errors + cmd_errors + flow_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// monitor, samples at the falling edge where everything is settled

	always @(negedge clock)
	begin
		if (rst_n)
		begin
			seen = {out_inst, out_label, out_addr, out_data_size, out_data_burstlen,
				out_wr_en, out_rd_en, out_addr_en, out_erase_en, out_dummy_en,
				out_dummy_burstlen, out_addr_mode_en, out_addr_dpi_mode,
				out_data_mode_en, out_data_dpi_mode};
			if (!started)
			begin
				assert (req_ready && !resp_valid && !out_valid)
				else
					log_error(flow_errors, "outputs not idle after reset");
				started = 1'b1;
			end
			// response exactly one cycle after each accept
			assert (resp_valid == accept_prev)
			else
				log_error(resp_errors, $sformatf("resp_valid %0b, accept %0b",
					resp_valid, accept_prev));
			if (resp_valid && resp_q.size() != 0)
			begin
				exp_cause = resp_q.pop_front();
				assert (resp_error == (exp_cause != 2'd0) && resp_cause == exp_cause)
				else
					log_error(resp_errors, $sformatf("error %0b cause %0d, expected %0d",
						resp_error, resp_cause, exp_cause));
			end
			// stalled word must hold
			if (stall_prev)
			begin
				assert (out_valid && seen == seen_prev)
				else
					log_error(cmd_errors, "output changed while stalled");
			end
			stall_prev = out_valid && !out_ready;
			seen_prev = seen;
			// buffer plus output register bound the outstanding commands
			assert (cmd_q.size() <= qspi_pkg::CMD_DEPTH + 1)
			else
				log_error(flow_errors, $sformatf("%0d commands outstanding", cmd_q.size()));
			if (cmd_q.size() == qspi_pkg::CMD_DEPTH + 1)
			begin
				assert (!req_ready)
				else
					log_error(flow_errors, "req_ready high with all slots taken");
			end
			// a word leaves on the coming edge
			if (out_valid && out_ready)
			begin
				if (cmd_q.size() == 0)
					log_error(cmd_errors, "command on output with none expected");
				else
				begin
					exp_cmd = cmd_q.pop_front();
					assert (seen == exp_cmd)
					else
						log_error(cmd_errors, $sformatf("command %h, expected %h",
							seen, exp_cmd));
				end
			end
			// accept on the coming edge, mode and write_enabled taken now
			accept_prev = req_valid && req_ready;
			if (accept_prev)
			begin
				accepted++;
				exp_cause = model_cause(req_inst, mode, write_enabled);
				resp_q.push_back(exp_cause);
				if (exp_cause == 2'd0)
					cmd_q.push_back(model_cmd(req_inst, req_label, req_addr,
						req_data_size, req_data_burstlen, mode));
			end
		end
	end

	// watchdog
	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

// ==== test/qspi_tb_clock.sv ====
`timescale 1ns/1ps

module qspi_tb_clock
(
	output logic clock,
	output logic rst_n
);

	// 4 ns period
	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// reset held over the first three rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clock);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== src/qspi_decode_top.sv ====
`timescale 1ns/1ps

module qspi_decode_top
(
	input  logic             clock,
	input  logic             rst_n,
	input  logic             req_valid,
	output logic             req_ready,
	input  qspi_pkg::inst_t  req_inst,
	input  logic             req_label,
	input  qspi_pkg::addr_t  req_addr,
	input  qspi_pkg::len_t   req_data_size,
	input  qspi_pkg::len_t   req_data_burstlen,
	input  qspi_pkg::mode_t  mode,
	input  logic             write_enabled,
	output logic             resp_valid,
	output logic             resp_error,
	output qspi_pkg::cause_t resp_cause,
	input  logic             out_ready,
	output logic             out_valid,
	output qspi_pkg::inst_t  out_inst,
	output logic             out_label,
	output qspi_pkg::addr_t  out_addr,
	output qspi_pkg::len_t   out_data_size,
	output qspi_pkg::len_t   out_data_burstlen,
	output logic             out_wr_en,
	output logic             out_rd_en,
	output logic             out_addr_en,
	output logic             out_erase_en,
	output logic             out_dummy_en,
	output qspi_pkg::len_t   out_dummy_burstlen,
	output logic             out_addr_mode_en,
	output logic             out_addr_dpi_mode,
	output logic             out_data_mode_en,
	output logic             out_data_dpi_mode
);

	// decoder to buffer, credit based
	logic push;
	qspi_pkg::cmd_word_t push_word;
	logic credit_return;

	// buffer to issue stage
	logic pop;
	logic head_valid;
	qspi_pkg::cmd_word_t head_word;

	// port names match the nets above one to one
	qspi_inst_decode decode0 (.*);

	qspi_cmd_fifo fifo0 (.*);

	qspi_cmd_issue issue0 (.*);

endmodule

// ==== src/qspi_cmd_issue.sv ====
`timescale 1ns/1ps

module qspi_cmd_issue
(
	input  logic                clock,
	input  logic                rst_n,
	input  logic                head_valid,
	input  qspi_pkg::cmd_word_t head_word,
	output logic                pop,
	input  logic                out_ready,
	output logic                out_valid,
	output qspi_pkg::inst_t     out_inst,
	output logic                out_label,
	output qspi_pkg::addr_t     out_addr,
	output qspi_pkg::len_t      out_data_size,
	output qspi_pkg::len_t      out_data_burstlen,
	output logic                out_wr_en,
	output logic                out_rd_en,
	output logic                out_addr_en,
	output logic                out_erase_en,
	output logic                out_dummy_en,
	output qspi_pkg::len_t      out_dummy_burstlen,
	output logic                out_addr_mode_en,
	output logic                out_addr_dpi_mode,
	output logic                out_data_mode_en,
	output logic                out_data_dpi_mode
);

	qspi_pkg::cmd_word_t word_q;

	// take the head when the register is empty or leaving this edge
	assign pop = head_valid && (!out_valid || out_ready);

	always_ff @(posedge clock)
	begin
		if (pop)
			word_q <= head_word;
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (pop)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// field unpack
	assign out_inst = word_q[qspi_pkg::CMD_INST_LSB +: qspi_pkg::INST_W];
	assign out_label = word_q[qspi_pkg::CMD_LABEL_LSB];
	assign out_addr = word_q[qspi_pkg::CMD_ADDR_LSB +: qspi_pkg::ADDR_W];
	assign out_data_size = word_q[qspi_pkg::CMD_DATA_SIZE_LSB +: qspi_pkg::LEN_W];
	assign out_data_burstlen = word_q[qspi_pkg::CMD_DATA_BURSTLEN_LSB +: qspi_pkg::LEN_W];
	assign out_wr_en = word_q[qspi_pkg::CMD_WR_EN_LSB];
	assign out_rd_en = word_q[qspi_pkg::CMD_RD_EN_LSB];
	assign out_addr_en = word_q[qspi_pkg::CMD_ADDR_EN_LSB];
	assign out_erase_en = word_q[qspi_pkg::CMD_ERASE_EN_LSB];
	assign out_dummy_en = word_q[qspi_pkg::CMD_DUMMY_EN_LSB];
	assign out_dummy_burstlen = word_q[qspi_pkg::CMD_DUMMY_BURSTLEN_LSB +: qspi_pkg::LEN_W];
	assign out_addr_mode_en = word_q[qspi_pkg::CMD_ADDR_MODE_EN_LSB];
	assign out_addr_dpi_mode = word_q[qspi_pkg::CMD_ADDR_DPI_MODE_LSB];
	assign out_data_mode_en = word_q[qspi_pkg::CMD_DATA_MODE_EN_LSB];
	assign out_data_dpi_mode = word_q[qspi_pkg::CMD_DATA_DPI_MODE_LSB];

	// a stalled word holds until the transfer level takes it
	a_stall_stable: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(word_q));

endmodule

// ==== src/qspi_cmd_fifo.sv ====
`timescale 1ns/1ps

module qspi_cmd_fifo
(
	input  logic                clock,
	input  logic                rst_n,
	input  logic                push,
	input  qspi_pkg::cmd_word_t push_word,
	input  logic                pop,
	output logic                head_valid,
	output qspi_pkg::cmd_word_t head_word,
	output logic                credit_return
);

	localparam qspi_pkg::ptr_t PTR_LAST = qspi_pkg::ptr_t'(qspi_pkg::CMD_DEPTH - 1);

	qspi_pkg::cmd_word_t mem [qspi_pkg::CMD_DEPTH];
	qspi_pkg::ptr_t wr_ptr;
	qspi_pkg::ptr_t rd_ptr;
	qspi_pkg::credit_t count;

	// storage
	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			// each pop frees a slot, handed back to the decoder next cycle
			credit_return <= pop;
			if (push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_valid = (count != '0);
	assign head_word = mem[rd_ptr];

	// the decoder only pushes against a credit, so a slot is always free
	a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
		push |-> count < qspi_pkg::CMD_DEPTH);
	// the issue stage only takes a word that is there
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n)
		pop |-> head_valid);

endmodule

// ==== src/qspi_inst_decode.sv ====
`timescale 1ns/1ps

module qspi_inst_decode
(
	input  logic                clock,
	input  logic                rst_n,
	input  logic                req_valid,
	output logic                req_ready,
	input  qspi_pkg::inst_t     req_inst,
	input  logic                req_label,
	input  qspi_pkg::addr_t     req_addr,
	input  qspi_pkg::len_t      req_data_size,
	input  qspi_pkg::len_t      req_data_burstlen,
	input  qspi_pkg::mode_t     mode,
	input  logic                write_enabled,
	output logic                resp_valid,
	output logic                resp_error,
	output qspi_pkg::cause_t    resp_cause,
	output logic                push,
	output qspi_pkg::cmd_word_t push_word,
	input  logic                credit_return
);

	qspi_pkg::credit_t credits;
	logic accept;
	logic is_spi;
	logic is_dpi;
	logic is_qpi;
	logic dummy_read;
	logic plain_read;
	logic write_data;
	logic just_inst;
	logic reg_read;
	logic reg_write;
	logic inst_addr;
	logic erase;
	logic illegal;
	logic wr_disabled;
	logic not_supported;
	logic xcpt;
	qspi_pkg::cause_t cause_next;
	qspi_pkg::len_t dummy_len;

	// ready while at least one buffer slot is still owed to us
	assign req_ready = (credits != '0);
	assign accept = req_valid && req_ready;

	assign is_spi = (mode == qspi_pkg::MODE_SPI);
	assign is_dpi = (mode == qspi_pkg::MODE_DPI);
	// mode 3 falls in with qpi
	assign is_qpi = (mode >= qspi_pkg::MODE_QPI);

	////////////////////////////////////////////////////////////
	// opcode classes
	assign dummy_read = req_inst inside {qspi_pkg::OP_FAST_READ, qspi_pkg::OP_DOFR,
		qspi_pkg::OP_DIOFR, qspi_pkg::OP_QIOFR, qspi_pkg::OP_ROTP, qspi_pkg::OP_QOFR};
	assign plain_read = (req_inst == qspi_pkg::OP_READ);
	assign write_data = req_inst inside {qspi_pkg::OP_PP, qspi_pkg::OP_DIFP,
		qspi_pkg::OP_DIEFP, qspi_pkg::OP_QIFP, qspi_pkg::OP_QIEFP, qspi_pkg::OP_POTP};
	assign just_inst = req_inst inside {qspi_pkg::OP_WREN, qspi_pkg::OP_WRDI,
		qspi_pkg::OP_CLFSR, qspi_pkg::OP_BE, qspi_pkg::OP_PER, qspi_pkg::OP_PES};
	assign reg_read = req_inst inside {qspi_pkg::OP_RDSR, qspi_pkg::OP_RDNVCR,
		qspi_pkg::OP_RDVCR, qspi_pkg::OP_RDVECR, qspi_pkg::OP_RFSR, qspi_pkg::OP_RDLR};
	assign reg_write = req_inst inside {qspi_pkg::OP_WRSR, qspi_pkg::OP_WRNVCR,
		qspi_pkg::OP_WRVCR, qspi_pkg::OP_WRVECR, qspi_pkg::OP_WRLR};
	assign inst_addr = req_inst inside {qspi_pkg::OP_SSE, qspi_pkg::OP_SE};
	// subsector, sector and bulk erase
	assign erase = req_inst inside {qspi_pkg::OP_SSE, qspi_pkg::OP_SE, qspi_pkg::OP_BE};

	////////////////////////////////////////////////////////////
	// exceptions, checked in priority order below
	assign illegal = !(dummy_read || plain_read || write_data || just_inst ||
		reg_read || reg_write || inst_addr);
	// only page programs need the write latch
	assign wr_disabled = !write_enabled && write_data;

	always_comb
	begin
		if (is_dpi)
			// quad transfers cannot run on a dual link
			not_supported = req_inst inside {qspi_pkg::OP_QOFR, qspi_pkg::OP_QIOFR,
				qspi_pkg::OP_QIFP, qspi_pkg::OP_QIEFP};
		else if (is_qpi)
			// dual transfers cannot run on a quad link
			not_supported = req_inst inside {qspi_pkg::OP_DOFR, qspi_pkg::OP_DIOFR,
				qspi_pkg::OP_DIFP, qspi_pkg::OP_DIEFP};
		else
			not_supported = 1'b0;
	end

	assign xcpt = illegal || wr_disabled || not_supported;

	always_comb
	begin
		if (illegal)
			cause_next = qspi_pkg::CAUSE_ILLEGAL;
		else if (wr_disabled)
			cause_next = qspi_pkg::CAUSE_WR_DISABLED;
		else if (not_supported)
			cause_next = qspi_pkg::CAUSE_NOT_SUPPORTED;
		else
			cause_next = qspi_pkg::CAUSE_NONE;
	end

	// one response per accept, a cycle later
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			resp_valid <= 1'b0;
			resp_error <= 1'b0;
			resp_cause <= qspi_pkg::CAUSE_NONE;
		end
		else
		begin
			resp_valid <= accept;
			if (accept)
			begin
				resp_error <= xcpt;
				resp_cause <= cause_next;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// command word toward the buffer
	assign dummy_len = is_spi ? qspi_pkg::DUMMY_LEN_SPI :
		is_dpi ? qspi_pkg::DUMMY_LEN_DPI : qspi_pkg::DUMMY_LEN_QPI;
	assign push = accept && !xcpt;

	always_comb
	begin
		push_word[qspi_pkg::CMD_INST_LSB +: qspi_pkg::INST_W] = req_inst;
		push_word[qspi_pkg::CMD_LABEL_LSB] = req_label;
		push_word[qspi_pkg::CMD_ADDR_LSB +: qspi_pkg::ADDR_W] = req_addr;
		push_word[qspi_pkg::CMD_DATA_SIZE_LSB +: qspi_pkg::LEN_W] = req_data_size;
		push_word[qspi_pkg::CMD_DATA_BURSTLEN_LSB +: qspi_pkg::LEN_W] = req_data_burstlen;
		push_word[qspi_pkg::CMD_WR_EN_LSB] = write_data || reg_write;
		push_word[qspi_pkg::CMD_RD_EN_LSB] = dummy_read || plain_read || reg_read;
		push_word[qspi_pkg::CMD_ADDR_EN_LSB] = write_data || plain_read || dummy_read ||
			inst_addr;
		push_word[qspi_pkg::CMD_ERASE_EN_LSB] = erase;
		push_word[qspi_pkg::CMD_DUMMY_EN_LSB] = dummy_read;
		push_word[qspi_pkg::CMD_DUMMY_BURSTLEN_LSB +: qspi_pkg::LEN_W] = dummy_len;
		// multi-line phase flags come straight from the opcode
		push_word[qspi_pkg::CMD_ADDR_MODE_EN_LSB] = req_inst inside {qspi_pkg::OP_DIOFR,
			qspi_pkg::OP_QIOFR, qspi_pkg::OP_DIFP, qspi_pkg::OP_DIEFP};
		push_word[qspi_pkg::CMD_ADDR_DPI_MODE_LSB] = req_inst inside {qspi_pkg::OP_QOFR,
			qspi_pkg::OP_DIEFP};
		push_word[qspi_pkg::CMD_DATA_MODE_EN_LSB] = req_inst inside {qspi_pkg::OP_DOFR,
			qspi_pkg::OP_DIOFR, qspi_pkg::OP_QOFR, qspi_pkg::OP_QIOFR, qspi_pkg::OP_DIFP,
			qspi_pkg::OP_QIFP};
		push_word[qspi_pkg::CMD_DATA_DPI_MODE_LSB] = req_inst inside {qspi_pkg::OP_DOFR,
			qspi_pkg::OP_DIOFR, qspi_pkg::OP_DIFP};
	end

	// credit counter, spent on push and refilled by the buffer
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			credits <= qspi_pkg::credit_t'(qspi_pkg::CMD_DEPTH);
		else if (push && !credit_return)
			credits <= credits - 1'b1;
		else if (credit_return && !push)
			credits <= credits + 1'b1;
	end

	// the buffer never hands back more credits than it was given
	a_credit_bound: assert property (@(posedge clock) disable iff (!rst_n)
		credits <= qspi_pkg::CMD_DEPTH);

endmodule

// ==== src/qspi_pkg.sv ====
package qspi_pkg;

	////////////////////////////////////////////////////////////
	// field widths
	localparam int INST_W = 8;
	localparam int ADDR_W = 24;
	localparam int LEN_W = 8;
	localparam int MODE_W = 2;
	localparam int CAUSE_W = 2;

	// buffer depth, also the number of credits the decoder starts with
	localparam int CMD_DEPTH = 4;
	localparam int PTR_W = $clog2(CMD_DEPTH);
	// one extra bit so the full count fits
	localparam int CREDIT_W = PTR_W + 1;

	typedef logic [INST_W-1:0] inst_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [MODE_W-1:0] mode_t;
	typedef logic [CAUSE_W-1:0] cause_t;
	typedef logic [CREDIT_W-1:0] credit_t;
	typedef logic [PTR_W-1:0] ptr_t;

	////////////////////////////////////////////////////////////
	// link modes, 3 behaves like qpi
	localparam mode_t MODE_SPI = 2'd0;
	localparam mode_t MODE_DPI = 2'd1;
	localparam mode_t MODE_QPI = 2'd2;

	// response causes
	localparam cause_t CAUSE_NONE = 2'd0;
	localparam cause_t CAUSE_ILLEGAL = 2'd1;
	localparam cause_t CAUSE_WR_DISABLED = 2'd2;
	localparam cause_t CAUSE_NOT_SUPPORTED = 2'd3;

	// dummy burst length per link mode
	localparam len_t DUMMY_LEN_SPI = 8'd2;
	localparam len_t DUMMY_LEN_DPI = 8'd4;
	localparam len_t DUMMY_LEN_QPI = 8'd10;

	////////////////////////////////////////////////////////////
	// command word, fields packed from the msb down
	localparam int CMD_W = 66;
	localparam int CMD_INST_LSB = CMD_W - INST_W;
	localparam int CMD_LABEL_LSB = CMD_INST_LSB - 1;
	localparam int CMD_ADDR_LSB = CMD_LABEL_LSB - ADDR_W;
	localparam int CMD_DATA_SIZE_LSB = CMD_ADDR_LSB - LEN_W;
	localparam int CMD_DATA_BURSTLEN_LSB = CMD_DATA_SIZE_LSB - LEN_W;
	localparam int CMD_WR_EN_LSB = CMD_DATA_BURSTLEN_LSB - 1;
	localparam int CMD_RD_EN_LSB = CMD_WR_EN_LSB - 1;
	localparam int CMD_ADDR_EN_LSB = CMD_RD_EN_LSB - 1;
	localparam int CMD_ERASE_EN_LSB = CMD_ADDR_EN_LSB - 1;
	localparam int CMD_DUMMY_EN_LSB = CMD_ERASE_EN_LSB - 1;
	localparam int CMD_DUMMY_BURSTLEN_LSB = CMD_DUMMY_EN_LSB - LEN_W;
	localparam int CMD_ADDR_MODE_EN_LSB = CMD_DUMMY_BURSTLEN_LSB - 1;
	localparam int CMD_ADDR_DPI_MODE_LSB = CMD_ADDR_MODE_EN_LSB - 1;
	localparam int CMD_DATA_MODE_EN_LSB = CMD_ADDR_DPI_MODE_LSB - 1;
	// lowest field ends up at bit 0
	localparam int CMD_DATA_DPI_MODE_LSB = CMD_DATA_MODE_EN_LSB - 1;

	typedef logic [CMD_W-1:0] cmd_word_t;

	////////////////////////////////////////////////////////////
	// n25q128 opcodes
	// reads with dummy cycles
	localparam inst_t OP_FAST_READ = 8'h0b;
	localparam inst_t OP_DOFR = 8'h3b;
	localparam inst_t OP_DIOFR = 8'hbb;
	localparam inst_t OP_QIOFR = 8'heb;
	localparam inst_t OP_ROTP = 8'h4b;
	localparam inst_t OP_QOFR = 8'h6b;
	// plain read
	localparam inst_t OP_READ = 8'h03;
	// page programs
	localparam inst_t OP_PP = 8'h02;
	localparam inst_t OP_DIFP = 8'ha2;
	localparam inst_t OP_DIEFP = 8'hd2;
	localparam inst_t OP_QIFP = 8'h32;
	localparam inst_t OP_QIEFP = 8'h12;
	localparam inst_t OP_POTP = 8'h42;
	// opcode only
	localparam inst_t OP_WREN = 8'h06;
	localparam inst_t OP_WRDI = 8'h04;
	localparam inst_t OP_CLFSR = 8'h50;
	localparam inst_t OP_BE = 8'hc7;
	localparam inst_t OP_PER = 8'h7a;
	localparam inst_t OP_PES = 8'h75;
	// register reads
	localparam inst_t OP_RDSR = 8'h05;
	localparam inst_t OP_RDNVCR = 8'hb5;
	localparam inst_t OP_RDVCR = 8'h85;
	localparam inst_t OP_RDVECR = 8'h65;
	localparam inst_t OP_RFSR = 8'h70;
	localparam inst_t OP_RDLR = 8'he8;
	// register writes
	localparam inst_t OP_WRSR = 8'h01;
	localparam inst_t OP_WRNVCR = 8'hb1;
	localparam inst_t OP_WRVCR = 8'h81;
	localparam inst_t OP_WRVECR = 8'h61;
	localparam inst_t OP_WRLR = 8'he5;
	// opcode plus address, both erases
	localparam inst_t OP_SSE = 8'h20;
	localparam inst_t OP_SE = 8'hd8;

endpackage
